/* sim.f */
rtl/uart_pkg.sv
rtl/rx_byte_if.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/rx_holding.sv
rtl/uart_link.sv
verification/uart_link_properties.sv
verification/uart_link_tb.sv

/* verification/uart_link_tb.sv */
`timescale 1ns/10ps

module uart_link_tb;

    localparam int FRAME_CLKS = 10 * uart_pkg::CLK_PER_BIT;
    localparam int WAIT_LIMIT = 3 * FRAME_CLKS;

    logic                 clk;
    logic                 arst;
    logic                 tx_req;
    uart_pkg::uart_byte_t tx_data;
    logic                 tx_ack;
    logic                 txd;
    logic                 rxd;
    logic                 rx_req;
    logic                 rx_ack;
    uart_pkg::uart_byte_t rx_data;
    logic                 rx_frame_err;
    logic                 rx_overrun;

    logic                 loopback;
    logic                 gen_rxd;
    int                   error_count;
    uart_pkg::uart_byte_t sent_q[$];

    assign rxd = loopback ? txd : gen_rxd;  // Serial line mux.

    uart_link dut0 (
        .clk          (clk),
        .arst         (arst),
        .tx_req       (tx_req),
        .tx_data      (tx_data),
        .tx_ack       (tx_ack),
        .txd          (txd),
        .rxd          (rxd),
        .rx_req       (rx_req),
        .rx_ack       (rx_ack),
        .rx_data      (rx_data),
        .rx_frame_err (rx_frame_err),
        .rx_overrun   (rx_overrun)
    );

    bind uart_link uart_link_properties props0 (
        .clk     (clk),
        .arst    (arst),
        .tx_req  (tx_req),
        .tx_ack  (tx_ack),
        .txd     (txd),
        .rx_req  (rx_req),
        .rx_ack  (rx_ack),
        .rx_data (rx_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_value(input string msg);
        error_count++;
        $display("Fail at %0t ns: %s", $time, msg);
        $display("Errors found");
        $fatal(1, "Simulation stopped after a wrong value.");
    endtask

    task automatic report_timeout(input string what);
        error_count++;
        $display("Timed out at %0t ns while waiting for %s", $time, what);
        $display("Errors found");
        $fatal(1, "Simulation stopped after a timeout.");
    endtask

    task automatic report_assertion();
        error_count++;
        $display("A protocol assertion in uart_link_properties failed before %0t ns", $time);
        $display("Errors found");
        $fatal(1, "Simulation stopped after an assertion failure.");
    endtask

    always @(posedge clk)
    begin
        if (dut0.props0.fail_count != 0)
            report_assertion();
    end

    task automatic compare_byte(input uart_pkg::uart_byte_t actual,
                                input uart_pkg::uart_byte_t expected, input string what);
        if (actual !== expected)
            report_value($sformatf("%s is %h, expected %h", what, actual, expected));
    endtask

    task automatic compare_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected)
            report_value($sformatf("%s is %b, expected %b", what, actual, expected));
    endtask

    task automatic wait_tx_ack(input logic level);
        int n;
        n = 0;
        @(posedge clk);
        while (tx_ack !== level)
        begin
            if (n >= WAIT_LIMIT)
                report_timeout($sformatf("tx_ack to become %b", level));
            @(posedge clk);
            n++;
        end
    endtask

    task automatic wait_rx_req(input logic level);
        int n;
        n = 0;
        @(posedge clk);
        while (rx_req !== level)
        begin
            if (n >= WAIT_LIMIT)
                report_timeout($sformatf("rx_req to become %b", level));
            @(posedge clk);
            n++;
        end
    endtask

    task automatic wait_txd(input logic level);
        int n;
        n = 0;
        @(posedge clk);
        while (txd !== level)
        begin
            if (n >= WAIT_LIMIT)
                report_timeout($sformatf("txd to become %b", level));
            @(posedge clk);
            n++;
        end
    endtask

    // Four-phase host transmit, held off while the previous frame runs.
    task automatic send_byte(input uart_pkg::uart_byte_t b);
        wait_tx_ack(1'b0);
        tx_req  <= 1'b1;
        tx_data <= b;
        wait_tx_ack(1'b1);
        tx_req  <= 1'b0;
        sent_q.push_back(b);
    endtask

    task automatic receive_byte(input logic exp_ferr, input logic exp_ovr);
        uart_pkg::uart_byte_t exp_data;
        exp_data = sent_q.pop_front();
        wait_rx_req(1'b1);
        compare_byte(rx_data, exp_data, "rx_data");
        compare_flag(rx_frame_err, exp_ferr, "rx_frame_err");
        compare_flag(rx_overrun, exp_ovr, "rx_overrun");
        rx_ack <= 1'b1;
        wait_rx_req(1'b0);
        rx_ack <= 1'b0;
    endtask

    // Short start lengths give a lone glitch with no data bits.
    task automatic drive_frame(input uart_pkg::uart_byte_t b, input logic stop_val,
                               input int start_len);
        int i;
        @(posedge clk);
        gen_rxd <= 1'b0;
        repeat (start_len) @(posedge clk);
        if (start_len < uart_pkg::CLK_PER_BIT)
            gen_rxd <= 1'b1;
        else
        begin
            for (i = 0; i < uart_pkg::DATA_BITS; i++)
            begin
                gen_rxd <= b[i];
                repeat (uart_pkg::CLK_PER_BIT) @(posedge clk);
            end
            gen_rxd <= stop_val;
            repeat (uart_pkg::CLK_PER_BIT) @(posedge clk);
            gen_rxd <= 1'b1;
            sent_q.push_back(b);
        end
        repeat (2 * uart_pkg::CLK_PER_BIT) @(posedge clk);
    endtask

    task automatic expect_no_req(input int cycles);
        repeat (cycles)
        begin
            @(posedge clk);
            compare_flag(rx_req, 1'b0, "rx_req while no byte is due");
        end
    endtask

    task automatic single_byte_loopback();
        send_byte(8'h3c);
        receive_byte(1'b0, 1'b0);
    endtask

    task automatic txd_frame_shape();
        uart_pkg::uart_byte_t b;
        int                   n;
        int                   idx;
        logic                 exp_bit;
        b = 8'hb2;
        wait_tx_ack(1'b0);
        tx_req  <= 1'b1;
        tx_data <= b;
        wait_txd(1'b0);
        compare_flag(tx_ack, 1'b1, "tx_ack at start bit");
        tx_req <= 1'b0;
        sent_q.push_back(b);
        for (n = 0; n < FRAME_CLKS; n++)
        begin
            compare_flag(tx_ack, 1'b1, "tx_ack during frame");
            if ((n % uart_pkg::CLK_PER_BIT) == (uart_pkg::HALF_BIT - 1))
            begin
                idx = n / uart_pkg::CLK_PER_BIT;
                if (idx == 0)
                    exp_bit = 1'b0;
                else if (idx <= uart_pkg::DATA_BITS)
                    exp_bit = b[idx-1];
                else
                    exp_bit = 1'b1;
                compare_flag(txd, exp_bit, $sformatf("txd bit slot %0d", idx));
            end
            @(posedge clk);
        end
        wait_tx_ack(1'b0);
        receive_byte(1'b0, 1'b0);
    endtask

    task automatic random_stream();
        int i;
        for (i = 0; i < 20; i++)
        begin
            send_byte(uart_pkg::uart_byte_t'($urandom));
            receive_byte(1'b0, 1'b0);
        end
    endtask

    task automatic stop_bit_error();
        drive_frame(8'ha5, 1'b0, uart_pkg::CLK_PER_BIT);
        receive_byte(1'b1, 1'b0);
        drive_frame(8'h5a, 1'b1, uart_pkg::CLK_PER_BIT);
        receive_byte(1'b0, 1'b0);
    endtask

    task automatic holding_overrun();
        drive_frame(8'h81, 1'b1, uart_pkg::CLK_PER_BIT);
        drive_frame(8'h7e, 1'b1, uart_pkg::CLK_PER_BIT);
        void'(sent_q.pop_back());   // Second byte never reaches the host.
        receive_byte(1'b0, 1'b1);
        expect_no_req(FRAME_CLKS);
    endtask

    task automatic false_start_reject();
        drive_frame(8'h00, 1'b1, uart_pkg::HALF_BIT / 2);
        expect_no_req(2 * FRAME_CLKS);
        drive_frame(8'hc3, 1'b1, uart_pkg::CLK_PER_BIT);
        receive_byte(1'b0, 1'b0);
    endtask

    initial
    begin
        error_count = 0;
        void'($urandom(32'h31f19f09));
        arst        <= 1'b1;
        tx_req      = 1'b0;
        tx_data     = '0;
        rx_ack      = 1'b0;
        loopback    = 1'b1;
        gen_rxd     = 1'b1;
        repeat (10) @(posedge clk);
        arst <= 1'b0;
        repeat (4) @(posedge clk);

        single_byte_loopback();
        txd_frame_shape();
        random_stream();

        @(posedge clk);
        loopback <= 1'b0;           // Generated frames from here on.
        stop_bit_error();
        holding_overrun();
        false_start_reject();

        repeat (4) @(posedge clk);
        if ((error_count == 0) && (dut0.props0.fail_count == 0))
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

/* verification/uart_link_properties.sv */
`timescale 1ns/10ps

module uart_link_properties (
    input logic                 clk,
    input logic                 arst,
    input logic                 tx_req,
    input logic                 tx_ack,
    input logic                 txd,
    input logic                 rx_req,
    input logic                 rx_ack,
    input uart_pkg::uart_byte_t rx_data
);

    int fail_count;

    // Host request must already be gone when ack falls.
    tx_ack_release: assert property (
        @(posedge clk) disable iff (arst)
        $fell(tx_ack) |-> !$past(tx_req)
    ) else
    begin
        fail_count++;
        $error("tx_ack fell while tx_req was still high");
    end

    rx_req_hold: assert property (
        @(posedge clk) disable iff (arst)
        (rx_req && !rx_ack) |=> rx_req
    ) else
    begin
        fail_count++;
        $error("rx_req dropped before rx_ack was seen");
    end

    rx_data_stable: assert property (
        @(posedge clk) disable iff (arst)
        (rx_req && $past(rx_req)) |-> $stable(rx_data)
    ) else
    begin
        fail_count++;
        $error("rx_data changed while rx_req was high");
    end

    // Line idles high through reset.
    txd_reset_idle: assert property (
        @(posedge clk)
        arst |-> txd
    ) else
    begin
        fail_count++;
        $error("txd was low while arst was asserted");
    end

endmodule

/* rtl/uart_link.sv */
`timescale 1ns/10ps

module uart_link (
    input  logic                 clk,
    input  logic                 arst,
    input  logic                 tx_req,
    input  uart_pkg::uart_byte_t tx_data,
    output logic                 tx_ack,
    output logic                 txd,
    input  logic                 rxd,
    output logic                 rx_req,
    input  logic                 rx_ack,
    output uart_pkg::uart_byte_t rx_data,
    output logic                 rx_frame_err,
    output logic                 rx_overrun
);

    rx_byte_if rx_bus ();

    uart_tx tx0 (
        .clk     (clk),
        .arst    (arst),
        .tx_req  (tx_req),
        .tx_data (tx_data),
        .tx_ack  (tx_ack),
        .txd     (txd)
    );

    uart_rx rx0 (
        .clk  (clk),
        .arst (arst),
        .rxd  (rxd),
        .out  (rx_bus.source)
    );

    rx_holding hold0 (
        .clk          (clk),
        .arst         (arst),
        .in           (rx_bus.sink),
        .rx_req       (rx_req),
        .rx_ack       (rx_ack),
        .rx_data      (rx_data),
        .rx_frame_err (rx_frame_err),
        .rx_overrun   (rx_overrun)
    );

endmodule

/* rtl/rx_holding.sv */
`timescale 1ns/10ps

module rx_holding (
    input  logic                 clk,
    input  logic                 arst,
    rx_byte_if.sink              in,
    output logic                 rx_req,
    input  logic                 rx_ack,
    output uart_pkg::uart_byte_t rx_data,
    output logic                 rx_frame_err,
    output logic                 rx_overrun
);

    logic xfer;
    logic free;
    logic load;

    // One sampled edge per transfer, while req and ack are both high.
    assign xfer = in.req & in.ack;
    assign free = ~rx_req & ~rx_ack;
    assign load = xfer & free;

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            rx_data      <= in.data;
            rx_frame_err <= in.frame_err;
        end
    end

    always_ff @(posedge clk or posedge arst)
    begin
        if (arst)
        begin
            in.ack     <= 1'b0;
            rx_req     <= 1'b0;
            rx_overrun <= 1'b0;
        end
        else
        begin
            in.ack <= in.req;   // Always accept.

            if (rx_ack)
                rx_req <= 1'b0;
            else if (load)
                rx_req <= 1'b1;

            // Entry busy, so the new byte is lost.
            if (load)
                rx_overrun <= 1'b0;
            else if (xfer)
                rx_overrun <= 1'b1;
        end
    end

endmodule

/* rtl/uart_rx.sv */
`timescale 1ns/10ps

module uart_rx (
    input  logic        clk,
    input  logic        arst,
    input  logic        rxd,
    rx_byte_if.source   out
);

    uart_pkg::rx_state_t            state;
    logic [uart_pkg::CNT_W-1:0]     clk_cnt;
    logic [uart_pkg::BIT_W-1:0]     bit_cnt;
    uart_pkg::uart_byte_t           shreg;
    logic                           rxd_meta;
    logic                           rxd_sync;
    logic                           rxd_prev;
    logic                           fall;
    logic                           bit_end;
    logic                           half_end;

    assign fall     = rxd_prev & ~rxd_sync;
    assign bit_end  = (clk_cnt == uart_pkg::BIT_LAST);
    assign half_end = (clk_cnt == uart_pkg::HALF_LAST);

    // Shift register holds the byte during handoff.
    assign out.data = shreg;

    always_ff @(posedge clk)
    begin
        if ((state == uart_pkg::RX_DATA) && bit_end)
            shreg <= {rxd_sync, shreg[uart_pkg::DATA_BITS-1:1]};    // LSB first.
        if ((state == uart_pkg::RX_STOP) && bit_end)
            out.frame_err <= ~rxd_sync;
    end

    always_ff @(posedge clk or posedge arst)
    begin
        if (arst)
        begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
            state    <= uart_pkg::RX_IDLE;
            clk_cnt  <= '0;
            bit_cnt  <= '0;
            out.req  <= 1'b0;
        end
        else
        begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
            case (state)
                uart_pkg::RX_IDLE:
                begin
                    clk_cnt <= '0;
                    bit_cnt <= '0;
                    if (fall)
                        state <= uart_pkg::RX_START;
                end
                uart_pkg::RX_START:
                begin
                    if (half_end)
                    begin
                        clk_cnt <= '0;
                        if (rxd_sync)
                            state <= uart_pkg::RX_IDLE;    // False start.
                        else
                            state <= uart_pkg::RX_DATA;
                    end
                    else
                        clk_cnt <= clk_cnt + 1'b1;
                end
                uart_pkg::RX_DATA:
                begin
                    if (bit_end)
                    begin
                        clk_cnt <= '0;
                        if (bit_cnt == uart_pkg::DATA_LAST)
                            state <= uart_pkg::RX_STOP;
                        else
                            bit_cnt <= bit_cnt + 1'b1;
                    end
                    else
                        clk_cnt <= clk_cnt + 1'b1;
                end
                uart_pkg::RX_STOP:
                begin
                    if (bit_end)
                    begin
                        clk_cnt <= '0;
                        out.req <= 1'b1;
                        state   <= uart_pkg::RX_HANDOFF;
                    end
                    else
                        clk_cnt <= clk_cnt + 1'b1;
                end
                uart_pkg::RX_HANDOFF:
                begin
                    if (out.ack)
                        out.req <= 1'b0;
                    else if (!out.req)
                        state <= uart_pkg::RX_IDLE;     // Both phases done.
                end
                default:
                    state <= uart_pkg::RX_IDLE;
            endcase
        end
    end

endmodule

/* rtl/uart_tx.sv */
`timescale 1ns/10ps

module uart_tx (
    input  logic                 clk,
    input  logic                 arst,
    input  logic                 tx_req,
    input  uart_pkg::uart_byte_t tx_data,
    output logic                 tx_ack,
    output logic                 txd
);

    uart_pkg::tx_state_t            state;
    logic [uart_pkg::CNT_W-1:0]     clk_cnt;
    logic [uart_pkg::BIT_W-1:0]     bit_cnt;
    uart_pkg::uart_byte_t           shreg;
    logic                           bit_end;
    logic                           accept;
    logic                           shift;

    assign bit_end = (clk_cnt == uart_pkg::BIT_LAST);
    assign accept  = (state == uart_pkg::TX_IDLE) && tx_req;
    assign shift   = bit_end && ((state == uart_pkg::TX_START) || (state == uart_pkg::TX_DATA));

    // Byte is captured at acceptance, then consumed LSB first.
    always_ff @(posedge clk)
    begin
        if (accept)
            shreg <= tx_data;
        else if (shift)
            shreg <= shreg >> 1;
    end

    always_ff @(posedge clk or posedge arst)
    begin
        if (arst)
        begin
            state   <= uart_pkg::TX_IDLE;
            clk_cnt <= '0;
            bit_cnt <= '0;
            tx_ack  <= 1'b0;
            txd     <= 1'b1;
        end
        else
        begin
            case (state)
                uart_pkg::TX_IDLE:
                begin
                    clk_cnt <= '0;
                    bit_cnt <= '0;
                    if (tx_req)
                    begin
                        tx_ack <= 1'b1;
                        txd    <= 1'b0;         // Start bit.
                        state  <= uart_pkg::TX_START;
                    end
                end
                uart_pkg::TX_START:
                begin
                    if (bit_end)
                    begin
                        clk_cnt <= '0;
                        txd     <= shreg[0];
                        state   <= uart_pkg::TX_DATA;
                    end
                    else
                        clk_cnt <= clk_cnt + 1'b1;
                end
                uart_pkg::TX_DATA:
                begin
                    if (bit_end)
                    begin
                        clk_cnt <= '0;
                        if (bit_cnt == uart_pkg::DATA_LAST)
                        begin
                            txd   <= 1'b1;      // Stop bit.
                            state <= uart_pkg::TX_STOP;
                        end
                        else
                        begin
                            bit_cnt <= bit_cnt + 1'b1;
                            txd     <= shreg[0];
                        end
                    end
                    else
                        clk_cnt <= clk_cnt + 1'b1;
                end
                uart_pkg::TX_STOP:
                begin
                    if (bit_end)
                    begin
                        clk_cnt <= '0;
                        if (!tx_req)
                        begin
                            tx_ack <= 1'b0;
                            state  <= uart_pkg::TX_IDLE;
                        end
                        else
                            state <= uart_pkg::TX_WAIT_RELEASE;
                    end
                    else
                        clk_cnt <= clk_cnt + 1'b1;
                end
                uart_pkg::TX_WAIT_RELEASE:
                begin
                    // Host still holds its request.
                    if (!tx_req)
                    begin
                        tx_ack <= 1'b0;
                        state  <= uart_pkg::TX_IDLE;
                    end
                end
                default:
                    state <= uart_pkg::TX_IDLE;
            endcase
        end
    end

endmodule

/* rtl/rx_byte_if.sv */
`timescale 1ns/10ps

interface rx_byte_if;

    logic                 req;
    logic                 ack;
    uart_pkg::uart_byte_t data;
    logic                 frame_err;   // Stop bit sampled low.

    modport source (
        output req,
        output data,
        output frame_err,
        input  ack
    );

    modport sink (
        input  req,
        input  data,
        input  frame_err,
        output ack
    );

endinterface

/* rtl/uart_pkg.sv */
package uart_pkg;

    // Serial bit timing in system clocks.
    localparam int CLK_PER_BIT = 16;
    localparam int HALF_BIT    = CLK_PER_BIT / 2;
    localparam int DATA_BITS   = 8;

    localparam int CNT_W = $clog2(CLK_PER_BIT);
    localparam int BIT_W = $clog2(DATA_BITS);

    // Terminal counts for the bit and sample counters.
    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(CLK_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(HALF_BIT - 1);
    localparam logic [BIT_W-1:0] DATA_LAST = BIT_W'(DATA_BITS - 1);

    typedef logic [DATA_BITS-1:0] uart_byte_t;

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP,
        TX_WAIT_RELEASE
    } tx_state_t;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP,
        RX_HANDOFF
    } rx_state_t;

endpackage
